//--- verilog/denise_defs.svh
////////////////////////////////////////////////////////////////////////////
// Denise video constants
// Register word addresses, beam positions and table sizes
////////////////////////////////////////////////////////////////////////////
`ifndef DENISE_DEFS_SVH
`define DENISE_DEFS_SVH

// Register word addresses (byte address / 2)
// STREQU/STRVBL/STRHOR/STRLONG at $038..$03E
`define DEN_ADDR_STR      8'h1C
`define DEN_ADDR_DIWSTRT  8'h47
`define DEN_ADDR_DIWSTOP  8'h48
`define DEN_ADDR_BPLCON0  8'h80
// BPL1DAT..BPL4DAT at $110..$116
`define DEN_ADDR_BPLDAT   8'h88
// COLOR00..COLOR15 at $180..$19E
`define DEN_ADDR_COLOR    8'hC0

// Beam positions
`define DEN_HPOS_RESTART  9'd2
`define DEN_HPOS_SOL      9'd32
`define DEN_HBLANK_START  9'h013
`define DEN_HBLANK_STOP   9'h061

// Table sizes
`define DEN_NUM_PLANES    4
`define DEN_NUM_COLORS    16

`endif

//--- verilog/denise_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Denise shared types
// Widths, state enums and the structs passed between blocks
////////////////////////////////////////////////////////////////////////////
package denise_pkg;

    // Plain vectors with a meaning
    typedef logic [8:0]  hpos_t;
    typedef logic [11:0] rgb12_t;
    typedef logic [3:0]  clut_idx_t;
    typedef logic [15:0] plane_word_t;
    typedef logic [7:0]  reg_addr_t;

    // Strobe kind, same order as the low address bits
    typedef enum logic [1:0] {
        STR_EQU  = 2'd0,
        STR_VBL  = 2'd1,
        STR_HOR  = 2'd2,
        STR_LONG = 2'd3
    } str_kind_e;

    // Line type of the beam
    typedef enum logic [1:0] {
        LINE_EQU = 2'd0,
        LINE_VBL = 2'd1,
        LINE_HOR = 2'd2
    } line_state_e;

    // Chip register write bus
    typedef struct packed {
        logic        wr;
        reg_addr_t   addr;
        logic [15:0] data;
    } reg_bus_t;

    typedef struct packed {
        logic      valid;
        str_kind_e kind;
    } strobe_t;

    // Window and plane count
    typedef struct packed {
        hpos_t      diw_start;
        hpos_t      diw_stop;
        logic [2:0] bpu;
    } disp_ctrl_t;

endpackage

//--- verilog/reg_decode.sv
////////////////////////////////////////////////////////////////////////////
// Register decoder
// Turns bus writes into strobes and write pulses, holds DIW and BPLCON0
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "denise_defs.svh"

module reg_decode (
    input  logic                     clk,
    input  logic                     reset,
    input  denise_pkg::reg_bus_t     bus,
    output denise_pkg::strobe_t      strobe,
    output denise_pkg::disp_ctrl_t   ctrl,
    output logic                     bpl_wr,
    output logic [1:0]               bpl_sel,
    output denise_pkg::plane_word_t  bpl_data,
    output logic                     color_wr,
    output denise_pkg::clut_idx_t    color_sel,
    output denise_pkg::rgb12_t       color_data
);

    localparam denise_pkg::reg_addr_t A_STR   = `DEN_ADDR_STR;
    localparam denise_pkg::reg_addr_t A_DIWB  = `DEN_ADDR_DIWSTRT;
    localparam denise_pkg::reg_addr_t A_DIWE  = `DEN_ADDR_DIWSTOP;
    localparam denise_pkg::reg_addr_t A_CON0  = `DEN_ADDR_BPLCON0;
    localparam denise_pkg::reg_addr_t A_BPL   = `DEN_ADDR_BPLDAT;
    localparam denise_pkg::reg_addr_t A_COLOR = `DEN_ADDR_COLOR;

    logic        str_p1;
    logic        diwb_p1;
    logic        diwe_p1;
    logic        ctl_p1;
    logic        bpl_p1;
    logic        clut_p1;
    logic [3:0]  addr_lo_p1;
    logic [15:0] data_p1;

    ////////////////////////////////////////////////////////////////////////////
    // Address match stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            str_p1  <= 1'b0;
            diwb_p1 <= 1'b0;
            diwe_p1 <= 1'b0;
            ctl_p1  <= 1'b0;
            bpl_p1  <= 1'b0;
            clut_p1 <= 1'b0;
        end else begin
            // Four strobes share one block of addresses
            str_p1  <= bus.wr && (bus.addr[7:2] == A_STR[7:2]);
            diwb_p1 <= bus.wr && (bus.addr == A_DIWB);
            diwe_p1 <= bus.wr && (bus.addr == A_DIWE);
            ctl_p1  <= bus.wr && (bus.addr == A_CON0);
            // Planes 1 to 4 only
            bpl_p1  <= bus.wr && (bus.addr[7:2] == A_BPL[7:2]);
            clut_p1 <= bus.wr && (bus.addr[7:4] == A_COLOR[7:4]);
        end
    end

    // Low address bits and data follow the match
    always_ff @(posedge clk) begin
        addr_lo_p1 <= bus.addr[3:0];
        data_p1    <= bus.data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window and plane control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.diw_start <= '0;
            ctrl.diw_stop  <= 9'h100;
            ctrl.bpu       <= '0;
        end else begin
            // Start lives in the left half of the line
            if (diwb_p1)
                ctrl.diw_start <= {1'b0, data_p1[7:0]};
            // Stop always in the right half
            if (diwe_p1)
                ctrl.diw_stop <= {1'b1, data_p1[7:0]};
            if (ctl_p1)
                ctrl.bpu <= data_p1[14:12];
        end
    end

    // Pulses to the downstream blocks
    assign strobe     = '{valid: str_p1, kind: denise_pkg::str_kind_e'(addr_lo_p1[1:0])};
    assign bpl_wr     = bpl_p1;
    assign bpl_sel    = addr_lo_p1[1:0];
    assign bpl_data   = data_p1;
    assign color_wr   = clut_p1;
    assign color_sel  = addr_lo_p1;
    assign color_data = data_p1[11:0];

endmodule

//--- verilog/beam_sync_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Beam line-type FSM
// Tracks the strobe type for vsync, vertical blanking and PAL/NTSC
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module beam_sync_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  denise_pkg::strobe_t  strobe,
    input  logic                 sol,
    output logic                 vsync,
    output logic                 vblank,
    output logic                 pal_ntsc
);

    denise_pkg::line_state_e state;
    logic [1:0]              str_cnt;
    logic                    str_short;

    // STRLONG is not a line type
    assign str_short = strobe.valid && (strobe.kind != denise_pkg::STR_LONG);

    ////////////////////////////////////////////////////////////////////////////
    // Line type
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= denise_pkg::LINE_HOR;
        end else if (str_short) begin
            case (strobe.kind)
                denise_pkg::STR_EQU: state <= denise_pkg::LINE_EQU;
                denise_pkg::STR_VBL: state <= denise_pkg::LINE_VBL;
                default:             state <= denise_pkg::LINE_HOR;
            endcase
        end
    end

    // Equalisation lines give vsync, sampled once per line
    always_ff @(posedge clk) begin
        if (reset)
            vsync <= 1'b0;
        else if (sol)
            vsync <= (state == denise_pkg::LINE_EQU);
    end

    // PAL sends three short strobes in a row, NTSC interleaves STRLONG
    always_ff @(posedge clk) begin
        if (reset)
            str_cnt <= 2'd0;
        else if (strobe.valid && (strobe.kind == denise_pkg::STR_LONG))
            str_cnt <= 2'd0;
        else if (str_short && (str_cnt != 2'd3))
            str_cnt <= str_cnt + 2'd1;
    end

    assign pal_ntsc = &str_cnt;
    assign vblank   = (state != denise_pkg::LINE_HOR);

endmodule

//--- verilog/hpos_counter.sv
////////////////////////////////////////////////////////////////////////////
// Horizontal beam counter
// Start of line, horizontal blanking and the display window latches
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "denise_defs.svh"

module hpos_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  denise_pkg::strobe_t     strobe,
    input  denise_pkg::disp_ctrl_t  ctrl,
    input  logic                    bpl_wr,
    output logic                    sol,
    output logic                    hblank,
    output logic                    hwin,
    output logic                    vwin
);

    denise_pkg::hpos_t hpos;
    denise_pkg::hpos_t hpos_nxt;
    logic              phase;
    logic              hold_pend;
    logic              restart;
    logic              str_long;

    assign restart  = strobe.valid && (strobe.kind != denise_pkg::STR_LONG);
    assign str_long = strobe.valid && (strobe.kind == denise_pkg::STR_LONG);

    // Count on every second clk, skip one step after STRLONG
    always_comb begin
        if (restart)
            hpos_nxt = `DEN_HPOS_RESTART;
        else if (phase && !hold_pend && !str_long)
            hpos_nxt = hpos + 9'd1;
        else
            hpos_nxt = hpos;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hpos      <= '0;
            phase     <= 1'b0;
            hold_pend <= 1'b0;
            sol       <= 1'b0;
        end else begin
            hpos  <= hpos_nxt;
            phase <= restart ? 1'b0 : ~phase;
            // Pending hold is used up by the next step
            if (restart || phase)
                hold_pend <= 1'b0;
            else if (str_long)
                hold_pend <= 1'b1;
            // One clk pulse on entry to position 32
            sol <= (hpos_nxt == `DEN_HPOS_SOL) && (hpos != `DEN_HPOS_SOL);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Blanking and window latches
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            hblank <= 1'b0;
            hwin   <= 1'b0;
            vwin   <= 1'b0;
        end else begin
            if (hpos == `DEN_HBLANK_START)
                hblank <= 1'b1;
            else if (hpos == `DEN_HBLANK_STOP)
                hblank <= 1'b0;
            if (hpos == ctrl.diw_start)
                hwin <= 1'b1;
            else if (hpos == ctrl.diw_stop)
                hwin <= 1'b0;
            // Plane DMA opens the line, blanking start closes it
            if (hpos == `DEN_HBLANK_START)
                vwin <= 1'b0;
            else if (bpl_wr)
                vwin <= 1'b1;
        end
    end

endmodule

//--- verilog/bitplane_shifter.sv
////////////////////////////////////////////////////////////////////////////
// Bitplane shifters
// Plane holding words, parallel load on BPL1DAT, one colour index per clk
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bitplane_shifter (
    input  logic                    clk,
    input  logic                    reset,
    input  denise_pkg::disp_ctrl_t  ctrl,
    input  logic                    bpl_wr,
    input  logic [1:0]              bpl_sel,
    input  denise_pkg::plane_word_t bpl_data,
    input  logic                    hwin,
    input  logic                    vwin,
    output denise_pkg::clut_idx_t   pix_idx
);

    // One index bit per plane
    localparam int NPL = $bits(denise_pkg::clut_idx_t);

    denise_pkg::plane_word_t hold [1:NPL-1];
    denise_pkg::plane_word_t shifter [NPL];
    denise_pkg::clut_idx_t   plane_en;
    denise_pkg::clut_idx_t   top_bits;
    logic                    load;

    // BPL1DAT is always the last word fetched
    assign load = bpl_wr && (bpl_sel == 2'd0);

    // Planes above BPU stay dark
    always_comb begin
        for (int i = 0; i < NPL; i++) begin
            plane_en[i] = (ctrl.bpu > 3'(i));
            top_bits[i] = shifter[i][15];
        end
    end

    // Plane 0 goes straight to its shifter
    always_ff @(posedge clk) begin
        for (int i = 1; i < NPL; i++) begin
            if (bpl_wr && (bpl_sel == 2'(i)))
                hold[i] <= bpl_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NPL; i++)
                shifter[i] <= '0;
        end else if (load) begin
            shifter[0] <= bpl_data & {16{plane_en[0]}};
            for (int i = 1; i < NPL; i++)
                shifter[i] <= hold[i] & {16{plane_en[i]}};
        end else begin
            // MSB first, zeros follow
            for (int i = 0; i < NPL; i++)
                shifter[i] <= {shifter[i][14:0], 1'b0};
        end
    end

    // Border shows colour 0
    always_ff @(posedge clk) begin
        if (reset)
            pix_idx <= '0;
        else
            pix_idx <= top_bits & {NPL{hwin & vwin}};
    end

endmodule

//--- verilog/palette_output.sv
////////////////////////////////////////////////////////////////////////////
// Colour table and video output
// 16 entry CLUT, composite blanking mask and RGB output registers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "denise_defs.svh"

module palette_output (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  color_wr,
    input  denise_pkg::clut_idx_t color_sel,
    input  denise_pkg::rgb12_t    color_data,
    input  denise_pkg::clut_idx_t pix_idx,
    input  logic                  hblank,
    input  logic                  vblank,
    output logic [3:0]            red,
    output logic [3:0]            green,
    output logic [3:0]            blue,
    output logic                  blank_n
);

    denise_pkg::rgb12_t clut [`DEN_NUM_COLORS];
    denise_pkg::rgb12_t rd_rgb;
    denise_pkg::rgb12_t out_rgb;
    logic               blank_d;

    ////////////////////////////////////////////////////////////////////////////
    // Colour look-up table
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (color_wr)
            clut[color_sel] <= color_data;
        // Read port, one clk behind the index
        rd_rgb <= clut[pix_idx];
    end

    // Blanking delayed to meet the read data
    always_ff @(posedge clk) begin
        if (reset)
            blank_d <= 1'b1;
        else
            blank_d <= hblank | vblank;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_rgb <= '0;
            blank_n <= 1'b0;
        end else if (blank_d) begin
            out_rgb <= '0;
            blank_n <= 1'b0;
        end else begin
            out_rgb <= rd_rgb;
            blank_n <= 1'b1;
        end
    end

    // Red in the top nibble
    assign red   = out_rgb[11:8];
    assign green = out_rgb[7:4];
    assign blue  = out_rgb[3:0];

endmodule

//--- verilog/denise_top.sv
////////////////////////////////////////////////////////////////////////////
// Reduced Denise video chip
// Bus decode, beam timing, four bitplanes and a 16 colour palette
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module denise_top (
    input  logic                 clk,
    input  logic                 reset,
    input  denise_pkg::reg_bus_t bus,
    output logic [3:0]           red,
    output logic [3:0]           green,
    output logic [3:0]           blue,
    output logic                 blank_n,
    output logic                 vsync,
    output logic                 sol,
    output logic                 pal_ntsc
);

    denise_pkg::strobe_t     strobe;
    denise_pkg::disp_ctrl_t  ctrl;
    logic                    bpl_wr;
    logic [1:0]              bpl_sel;
    denise_pkg::plane_word_t bpl_data;
    logic                    color_wr;
    denise_pkg::clut_idx_t   color_sel;
    denise_pkg::rgb12_t      color_data;
    logic                    hblank;
    logic                    hwin;
    logic                    vwin;
    logic                    vblank;
    denise_pkg::clut_idx_t   pix_idx;

    // Bus side
    reg_decode u_reg_decode (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .strobe     (strobe),
        .ctrl       (ctrl),
        .bpl_wr     (bpl_wr),
        .bpl_sel    (bpl_sel),
        .bpl_data   (bpl_data),
        .color_wr   (color_wr),
        .color_sel  (color_sel),
        .color_data (color_data)
    );

    // Beam timing
    beam_sync_fsm u_beam_sync_fsm (
        .clk      (clk),
        .reset    (reset),
        .strobe   (strobe),
        .sol      (sol),
        .vsync    (vsync),
        .vblank   (vblank),
        .pal_ntsc (pal_ntsc)
    );

    hpos_counter u_hpos_counter (
        .clk    (clk),
        .reset  (reset),
        .strobe (strobe),
        .ctrl   (ctrl),
        .bpl_wr (bpl_wr),
        .sol    (sol),
        .hblank (hblank),
        .hwin   (hwin),
        .vwin   (vwin)
    );

    // Pixel path
    bitplane_shifter u_bitplane_shifter (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .bpl_wr   (bpl_wr),
        .bpl_sel  (bpl_sel),
        .bpl_data (bpl_data),
        .hwin     (hwin),
        .vwin     (vwin),
        .pix_idx  (pix_idx)
    );

    palette_output u_palette_output (
        .clk        (clk),
        .reset      (reset),
        .color_wr   (color_wr),
        .color_sel  (color_sel),
        .color_data (color_data),
        .pix_idx    (pix_idx),
        .hblank     (hblank),
        .vblank     (vblank),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .blank_n    (blank_n)
    );

endmodule

//--- dv/denise_tb.sv
////////////////////////////////////////////////////////////////////////////
// Denise testbench
// Table-driven checks of beam timing, sync flags, pixels and blanking
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "denise_defs.svh"

module denise_tb;

    // Check mask and expected flags, order {sol, vsync, pal_ntsc, blank_n}
    localparam logic [3:0] C_NONE = 4'b0000;
    localparam logic [3:0] C_SOL  = 4'b1000;
    localparam logic [3:0] C_VS   = 4'b0100;
    localparam logic [3:0] C_PAL  = 4'b0010;
    localparam logic [3:0] C_BLK  = 4'b0001;

    // Strobe addresses
    localparam logic [7:0] A_EQU  = `DEN_ADDR_STR;
    localparam logic [7:0] A_VBL  = `DEN_ADDR_STR + 8'd1;
    localparam logic [7:0] A_HOR  = `DEN_ADDR_STR + 8'd2;
    localparam logic [7:0] A_LONG = `DEN_ADDR_STR + 8'd3;

    // One row of the stimulus table
    typedef struct packed {
        logic        wr;
        logic [7:0]  addr;
        logic [15:0] data;
        logic [9:0]  wait_cyc;
        logic [3:0]  chk;
        logic [3:0]  want;
        logic [2:0]  pix_bpu;
    } step_t;

    logic                 clk;
    logic                 reset;
    denise_pkg::reg_bus_t bus;
    logic [3:0]           red;
    logic [3:0]           green;
    logic [3:0]           blue;
    logic                 blank_n;
    logic                 vsync;
    logic                 sol;
    logic                 pal_ntsc;

    step_t       steps[$];
    logic [15:0] plane_words [4];
    logic [11:0] color_tab [16];
    logic [11:0] exp_pix [16];
    logic [15:0] lfsr;
    int          budget;

    denise_top dut (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .blank_n  (blank_n),
        .vsync    (vsync),
        .sol      (sol),
        .pal_ntsc (pal_ntsc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit of the word
    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[14:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic void write_step(input logic [7:0] addr, input logic [15:0] data,
            input int wait_cyc, input logic [3:0] chk, input logic [3:0] want,
            input logic [2:0] bpu);
        step_t s;
        s = '{1'b1, addr, data, 10'(wait_cyc), chk, want, bpu};
        steps.push_back(s);
    endfunction

    function automatic void idle_step(input int wait_cyc, input logic [3:0] chk,
            input logic [3:0] want);
        step_t s;
        s = '{1'b0, 8'h00, 16'h0000, 10'(wait_cyc), chk, want, 3'd0};
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        // Line restart, sol 61 clk after the strobe, STRLONG adds 2
        write_step(A_HOR, 16'h0000, 60, C_SOL | C_VS | C_PAL, 4'b0000, 3'd0);
        idle_step(1, C_SOL | C_BLK, 4'b1000);
        idle_step(1, C_SOL, 4'b0000);
        write_step(A_HOR, 16'h0000, 4, C_PAL, 4'b0000, 3'd0);
        write_step(A_LONG, 16'h0000, 56, C_SOL | C_PAL, 4'b0000, 3'd0);
        idle_step(1, C_SOL, 4'b1000);
        idle_step(1, C_SOL, 4'b0000);
        // vsync on equalisation lines, PAL after three short strobes
        write_step(A_EQU, 16'h0000, 60, C_SOL | C_VS | C_PAL, 4'b0000, 3'd0);
        idle_step(3, C_SOL | C_VS | C_BLK, 4'b0100);
        write_step(A_HOR, 16'h0000, 60, C_VS | C_PAL, 4'b0100, 3'd0);
        idle_step(3, C_VS, 4'b0000);
        write_step(A_VBL, 16'h0000, 60, C_VS | C_PAL | C_BLK, 4'b0010, 3'd0);
        write_step(A_LONG, 16'h0000, 2, C_PAL, 4'b0000, 3'd0);
        // Window 0x70 to 0xC0, four planes, colour table
        write_step(`DEN_ADDR_DIWSTRT, 16'h0070, 0, C_NONE, 4'b0000, 3'd0);
        write_step(`DEN_ADDR_DIWSTOP, 16'h00C0, 0, C_NONE, 4'b0000, 3'd0);
        write_step(`DEN_ADDR_BPLCON0, 16'h4000, 0, C_NONE, 4'b0000, 3'd0);
        for (int i = 0; i < `DEN_NUM_COLORS; i++)
            write_step(`DEN_ADDR_COLOR + 8'(i), {4'h0, color_tab[i]}, 0, C_NONE,
                       4'b0000, 3'd0);
        // Planes written near position 0x83, BPL1DAT last
        write_step(A_HOR, 16'h0000, 260, C_VS | C_PAL | C_BLK, 4'b0001, 3'd0);
        for (int p = 1; p < `DEN_NUM_PLANES; p++)
            write_step(`DEN_ADDR_BPLDAT + 8'(p), plane_words[p], 0, C_NONE, 4'b0000, 3'd0);
        write_step(`DEN_ADDR_BPLDAT, plane_words[0], 3, C_NONE, 4'b0000, 3'd4);
        // Two planes enabled, same words
        write_step(`DEN_ADDR_BPLCON0, 16'h2000, 0, C_NONE, 4'b0000, 3'd0);
        write_step(`DEN_ADDR_BPLDAT, plane_words[0], 3, C_NONE, 4'b0000, 3'd2);
        // Loaded planes under hblank at sol, then on a VBL line
        write_step(A_HOR, 16'h0000, 54, C_SOL, 4'b0000, 3'd0);
        write_step(`DEN_ADDR_BPLDAT, plane_words[0], 5, C_SOL | C_BLK, 4'b1000, 3'd0);
        idle_step(1, C_SOL | C_BLK, 4'b0000);
        write_step(A_VBL, 16'h0000, 260, C_VS | C_BLK, 4'b0000, 3'd0);
        write_step(`DEN_ADDR_BPLDAT, plane_words[0], 6, C_BLK, 4'b0000, 3'd0);
    endfunction

    function automatic int table_cycles();
        int n;
        n = 0;
        foreach (steps[i])
            n += (steps[i].wr ? 2 : 0) + int'(steps[i].wait_cyc) + 1
                 + ((steps[i].pix_bpu != 3'd0) ? 16 : 0);
        return n;
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] want);
        if (got !== want) begin
            $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One clk write, sampled by the DUT at the second edge
    task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
        @(posedge clk);
        bus <= '{wr: 1'b1, addr: addr, data: data};
        @(posedge clk);
        bus.wr <= 1'b0;
    endtask

    // Pixel k = {bit k of planes 3..0}, MSB first, planes above BPU dark
    task automatic pixel_run(input logic [2:0] bpu);
        logic [3:0] idx;
        for (int k = 0; k < 16; k++) begin
            for (int p = 0; p < 4; p++)
                idx[p] = plane_words[p][15-k] && (int'(bpu) > p);
            exp_pix[k] = color_tab[idx];
        end
        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_value("blank_n in window", 16'(blank_n), 16'h0001);
            check_value($sformatf("pixel %0d", k), 16'({red, green, blue}),
                        16'(exp_pix[k]));
        end
    endtask

    task automatic run_step(input step_t s);
        if (s.wr)
            bus_write(s.addr, s.data);
        repeat (int'(s.wait_cyc)) @(posedge clk);
        // Outputs settle away from the rising edge
        @(negedge clk);
        if (s.chk[3])
            check_value("sol", 16'(sol), 16'(s.want[3]));
        if (s.chk[2])
            check_value("vsync", 16'(vsync), 16'(s.want[2]));
        if (s.chk[1])
            check_value("pal_ntsc", 16'(pal_ntsc), 16'(s.want[1]));
        if (s.chk[0]) begin
            check_value("blank_n", 16'(blank_n), 16'(s.want[0]));
            if (!s.want[0])
                check_value("blanked rgb", 16'({red, green, blue}), 16'h0000);
        end
        if (s.pix_bpu != 3'd0)
            pixel_run(s.pix_bpu);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Clock, stimulus and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        bus   = '0;
        lfsr  = 16'd61;
        for (int p = 0; p < 4; p++)
            plane_words[p] = random_word();
        // Odd multiplier keeps all 16 colours distinct
        for (int i = 0; i < 16; i++)
            color_tab[i] = 12'(i * 241) ^ 12'hA5C;
        build_table();
        budget = 8 + table_cycles();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        foreach (steps[i])
            run_step(steps[i]);
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        @(posedge clk);
        repeat (budget + 100) @(posedge clk);
        $display("Watchdog expired after %0d cycles", budget + 100);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation timed out");
    end

endmodule

//--- list.f
+incdir+verilog
verilog/denise_pkg.sv
verilog/reg_decode.sv
verilog/beam_sync_fsm.sv
verilog/hpos_counter.sv
verilog/bitplane_shifter.sv
verilog/palette_output.sv
verilog/denise_top.sv
dv/denise_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= denise_tb
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
